//--- compile.f
hw/md_pkg.sv
hw/ds_rs_if.sv
hw/cdb_if.sv
hw/prf.sv
hw/intm_rs.sv
hw/fu_md.sv
hw/md_core.sv
sim/md_checker.sv
sim/tb_md_core.sv

//--- sim/tb_md_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_md_core
    import md_pkg::*;
();

    localparam int clk_period   = 20;
    // ops over all tests, 40 cycles each plus setup
    localparam int op_count     = 262;
    localparam int limit_cycles = op_count * 40 + 1000;

    logic    clk;
    logic    rst;
    logic    disp_valid;
    logic    disp_ready;
    rob_id_t disp_rob_id;
    phy_t    disp_rd_phy;
    arch_t   disp_rd_arch;
    md_op_t  disp_op;
    phy_t    disp_rs1_phy;
    phy_t    disp_rs2_phy;
    logic    disp_rs1_valid;
    logic    disp_rs2_valid;
    logic    ext_wb_valid;
    rob_id_t ext_wb_rob_id;
    phy_t    ext_wb_rd_phy;
    arch_t   ext_wb_rd_arch;
    xlen_t   ext_wb_value;
    logic    res_valid;
    rob_id_t res_rob_id;
    phy_t    res_rd_phy;
    arch_t   res_rd_arch;
    xlen_t   res_value;

    // value each register will hold once its producer is done
    xlen_t   shadow [PRF_DEPTH];
    rob_id_t next_rob;
    phy_t    next_phy;
    // pending sources not yet written through ext_wb
    phy_t    pend_q [$];

    // operand pairs, p1..p4 hold corner values
    phy_t mul_a [5] = '{1, 2, 1, 3, 5};
    phy_t mul_b [5] = '{2, 2, 1, 1, 6};
    phy_t div_a [6] = '{1, 7, 1, 9, 10, 11};
    phy_t div_b [6] = '{2, 0, 0, 4, 2, 12};

    md_core md_core_inst (.*);

    md_checker md_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res_rob_id  (res_rob_id),
        .res_rd_phy  (res_rd_phy),
        .res_rd_arch (res_rd_arch),
        .res_value   (res_value)
    );

    always #(clk_period / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // reference model, RISC-V M rules on 64 bit products
    // ------------------------------------------------------------------

    function automatic xlen_t md_ref(input md_op_t op, input xlen_t a, input xlen_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        logic        ovf;
        ea   = {{32{a[31] && (op == OP_MULH || op == OP_MULHSU)}}, a};
        eb   = {{32{b[31] && (op == OP_MULH)}}, b};
        prod = ea * eb;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            OP_MUL: return prod[31:0];
            OP_MULH, OP_MULHSU, OP_MULHU: return prod[63:32];
            OP_DIV: begin
                if (b == '0) return '1;
                if (ovf) return a;
                return $signed(a) / $signed(b);
            end
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0) return a;
                if (ovf) return '0;
                return $signed(a) % $signed(b);
            end
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------

    // rd and pending regs rotate through p32..p63
    function automatic phy_t alloc_phy();
        phy_t p;
        p        = next_phy;
        next_phy = (next_phy == phy_t'(PRF_DEPTH - 1)) ? phy_t'(32) : next_phy + phy_t'(1);
        return p;
    endfunction

    function automatic xlen_t pick_value();
        case ($urandom_range(0, 7))
            0: return 32'h8000_0000;
            1: return 32'hffff_ffff;
            2: return '0;
            3: return 32'h1;
            default: return $urandom();
        endcase
    endfunction

    // fresh reg, value fixed now, written later
    function automatic phy_t pending_src();
        phy_t p;
        p         = alloc_phy();
        shadow[p] = pick_value();
        pend_q.push_back(p);
        return p;
    endfunction

    // one cycle broadcast on lane 0
    task automatic ext_write(input phy_t p, input xlen_t v);
        shadow[p]      = v;
        ext_wb_valid   = 1'b1;
        ext_wb_rd_phy  = p;
        ext_wb_value   = v;
        ext_wb_rob_id  = rob_id_t'($urandom());
        ext_wb_rd_arch = arch_t'($urandom());
        @(negedge clk);
        ext_wb_valid   = 1'b0;
    endtask

    task automatic flush_writes(input int keep);
        phy_t p;
        while (pend_q.size() > keep) begin
            p = pend_q.pop_front();
            ext_write(p, shadow[p]);
        end
    endtask

    // holds valid until the station takes it
    task automatic send_op(input md_op_t op, input phy_t s1, input logic v1,
                           input phy_t s2, input logic v2, input phy_t rd);
        xlen_t expected;
        arch_t arch;
        expected = md_ref(op, shadow[s1], shadow[s2]);
        arch     = arch_t'($urandom());
        md_checker_inst.add_expect(next_rob, rd, arch, expected);
        shadow[rd]     = expected;
        disp_valid     = 1'b1;
        disp_rob_id    = next_rob;
        disp_rd_phy    = rd;
        disp_rd_arch   = arch;
        disp_op        = op;
        disp_rs1_phy   = s1;
        disp_rs1_valid = v1;
        disp_rs2_phy   = s2;
        disp_rs2_valid = v2;
        next_rob       = next_rob + rob_id_t'(1);
        while (!disp_ready) @(negedge clk);
        @(negedge clk);
        disp_valid     = 1'b0;
    endtask

    // empty unit, so latency is counted from the push edge
    task automatic lone_op(input md_op_t op, input phy_t s1, input phy_t s2,
                           input int lat_exp);
        int lat;
        lat = 0;
        send_op(op, s1, 1'b1, s2, 1'b1, alloc_phy());
        while (!res_valid && lat < 100) begin
            @(negedge clk);
            lat++;
        end
        if (lat != lat_exp) begin
            md_checker_inst.note_error($sformatf("FAIL res_valid latency %s exp %h got %h",
                                                 op.name(), lat_exp, lat));
        end
        md_checker_inst.drain();
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------

    initial begin
        phy_t   s1;
        phy_t   s2;
        phy_t   rd;
        phy_t   blk;
        phy_t   blk2;
        logic   v1;
        logic   v2;
        void'($urandom(3590));
        clk            = 1'b0;
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp_rob_id    = '0;
        disp_rd_phy    = '0;
        disp_rd_arch   = '0;
        disp_op        = OP_MUL;
        disp_rs1_phy   = '0;
        disp_rs2_phy   = '0;
        disp_rs1_valid = 1'b0;
        disp_rs2_valid = 1'b0;
        ext_wb_valid   = 1'b0;
        ext_wb_rob_id  = '0;
        ext_wb_rd_phy  = '0;
        ext_wb_rd_arch = '0;
        ext_wb_value   = '0;
        for (int i = 0; i < PRF_DEPTH; i++) begin
            shadow[i] = '0;
        end
        next_rob = '0;
        next_phy = phy_t'(32);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        if (!disp_ready || res_valid) begin
            md_checker_inst.note_error("ready or result lane wrong after reset");
        end

        // p1..p31 stay fixed as ready sources
        ext_write(phy_t'(1), 32'h8000_0000);
        ext_write(phy_t'(2), 32'hffff_ffff);
        ext_write(phy_t'(3), 32'h7fff_ffff);
        ext_write(phy_t'(4), 32'h1);
        for (int i = 5; i < 32; i++) begin
            ext_write(phy_t'(i), $urandom());
        end

        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 5; j++) begin
                lone_op(md_op_t'(k), mul_a[j], mul_b[j], 3);
            end
        end
        md_checker_inst.end_test("multiply");

        // includes -2^31 / -1 and x / 0
        for (int k = 4; k < 8; k++) begin
            for (int j = 0; j < 6; j++) begin
                lone_op(md_op_t'(k), div_a[j], div_b[j], 34);
            end
        end
        md_checker_inst.end_test("divide");

        // all four wait, none may finish before its write
        for (int j = 0; j < 4; j++) begin
            s1 = pending_src();
            v2 = (j % 2 == 1);
            s2 = v2 ? phy_t'($urandom_range(1, 31)) : pending_src();
            send_op(md_op_t'($urandom_range(0, 7)), s1, 1'b0, s2, v2, alloc_phy());
        end
        repeat (10) @(negedge clk);
        if (md_checker_inst.outstanding() != 4) begin
            md_checker_inst.note_error("a result arrived before its source was written");
        end
        flush_writes(0);
        md_checker_inst.end_test("wakeup");

        // divide, then two consumers fed by the md lane
        for (int c = 0; c < 3; c++) begin
            s1 = alloc_phy();
            s2 = alloc_phy();
            rd = alloc_phy();
            send_op(md_op_t'($urandom_range(4, 7)), phy_t'($urandom_range(1, 31)), 1'b1,
                    phy_t'($urandom_range(1, 31)), 1'b1, s1);
            send_op(md_op_t'($urandom_range(0, 7)), s1, 1'b0,
                    phy_t'($urandom_range(1, 31)), 1'b1, s2);
            send_op(md_op_t'($urandom_range(0, 7)), s2, 1'b0, s1, 1'b0, rd);
            md_checker_inst.drain();
        end
        md_checker_inst.end_test("chain");

        // four fill the station, the fifth waits on dispatch
        blk          = alloc_phy();
        blk2         = alloc_phy();
        shadow[blk]  = pick_value();
        shadow[blk2] = pick_value();
        for (int j = 0; j < 4; j++) begin
            send_op(md_op_t'($urandom_range(0, 7)), blk, 1'b0,
                    phy_t'($urandom_range(1, 31)), 1'b1, alloc_phy());
        end
        if (disp_ready !== 1'b0) begin
            md_checker_inst.note_error($sformatf("FAIL disp_ready exp %h got %h",
                                                 1'b0, disp_ready));
        end
        rd = alloc_phy();
        fork
            send_op(md_op_t'($urandom_range(0, 7)), blk2, 1'b0,
                    phy_t'($urandom_range(1, 31)), 1'b1, rd);
            begin
                repeat (3) @(negedge clk);
                ext_write(blk, shadow[blk]);
            end
        join
        ext_write(blk2, shadow[blk2]);
        md_checker_inst.end_test("backpressure");

        // batches of 8, one pending write kept back
        for (int n = 0; n < 200; n++) begin
            v1 = ($urandom_range(0, 2) != 0);
            s1 = v1 ? phy_t'($urandom_range(0, 31)) : pending_src();
            v2 = ($urandom_range(0, 2) != 0);
            s2 = v2 ? phy_t'($urandom_range(0, 31)) : pending_src();
            send_op(md_op_t'($urandom_range(0, 7)), s1, v1, s2, v2, alloc_phy());
            flush_writes(1);
            if (n % 8 == 7) begin
                flush_writes(0);
                md_checker_inst.drain();
            end
        end
        md_checker_inst.end_test("random mix");

        md_checker_inst.summary();
        if (md_checker_inst.error_total() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(limit_cycles * clk_period);
        $display("watchdog expired after %0d cycles, run stopped", limit_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/md_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the result lane and scoreboards by rob id
module md_checker
    import md_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    res_valid,
    input rob_id_t res_rob_id,
    input phy_t    res_rd_phy,
    input arch_t   res_rd_arch,
    input xlen_t   res_value
);

    localparam int rob_count   = 2 ** ROB_W;
    localparam int drain_limit = 2000;

    // one slot per rob tag
    logic [rob_count-1:0] pend = '0;
    phy_t                 exp_phy  [rob_count];
    arch_t                exp_arch [rob_count];
    xlen_t                exp_val  [rob_count];

    // per test and running totals
    int test_checks  = 0;
    int test_errs    = 0;
    int tests_run    = 0;
    int tests_bad    = 0;
    int total_checks = 0;
    int total_errs   = 0;

    task automatic note_error(input string msg);
        $display("%s", msg);
        test_errs++;
    endtask

    function automatic int outstanding();
        return $countones(pend);
    endfunction

    function automatic int error_total();
        return total_errs + test_errs;
    endfunction

    // called at dispatch
    task automatic add_expect(input rob_id_t rob, input phy_t phy, input arch_t arch,
                              input xlen_t val);
        if (pend[rob]) begin
            note_error($sformatf("rob_id %0d dispatched again while still in flight", rob));
        end
        pend[rob]     = 1'b1;
        exp_phy[rob]  = phy;
        exp_arch[rob] = arch;
        exp_val[rob]  = val;
    endtask

    // ------------------------------------------------------------------
    // compare
    // ------------------------------------------------------------------

    // lane is one cycle wide, middle of the cycle is stable
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            if (!pend[res_rob_id]) begin
                note_error($sformatf("result for rob_id %0d with no op in flight",
                                     res_rob_id));
            end else begin
                pend[res_rob_id] = 1'b0;
                test_checks++;
                if (res_value !== exp_val[res_rob_id]) begin
                    note_error($sformatf("FAIL res_value rob_id %0d exp %h got %h",
                                         res_rob_id, exp_val[res_rob_id], res_value));
                end
                if (res_rd_phy !== exp_phy[res_rob_id]) begin
                    note_error($sformatf("FAIL res_rd_phy rob_id %0d exp %h got %h",
                                         res_rob_id, exp_phy[res_rob_id], res_rd_phy));
                end
                if (res_rd_arch !== exp_arch[res_rob_id]) begin
                    note_error($sformatf("FAIL res_rd_arch rob_id %0d exp %h got %h",
                                         res_rob_id, exp_arch[res_rob_id], res_rd_arch));
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // test bookkeeping
    // ------------------------------------------------------------------

    // wait for every op in flight, name the ones that never came back
    task automatic drain();
        int waited;
        waited = 0;
        while (outstanding() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (outstanding() != 0) begin
            for (int i = 0; i < rob_count; i++) begin
                if (pend[i]) begin
                    note_error($sformatf("no result arrived for rob_id %0d", i));
                end
            end
            pend = '0;
        end
    endtask

    task automatic end_test(input string name);
        drain();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %-12s ok, %0d results checked", name, test_checks);
        end else begin
            $display("test %-12s has %0d errors in %0d results", name, test_errs,
                     test_checks);
            tests_bad++;
        end
        total_checks += test_checks;
        total_errs   += test_errs;
        test_checks   = 0;
        test_errs     = 0;
    endtask

    task automatic summary();
        $display("done: %0d tests run, %0d with errors, %0d results checked, %0d errors",
                 tests_run, tests_bad, total_checks, total_errs);
    endtask

endmodule

`default_nettype wire

//--- hw/md_core.sv
`timescale 1ns/1ps
`default_nettype none

module md_core
    import md_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // dispatch
    input  logic    disp_valid,
    output logic    disp_ready,
    input  rob_id_t disp_rob_id,
    input  phy_t    disp_rd_phy,
    input  arch_t   disp_rd_arch,
    input  md_op_t  disp_op,
    input  phy_t    disp_rs1_phy,
    input  phy_t    disp_rs2_phy,
    input  logic    disp_rs1_valid,
    input  logic    disp_rs2_valid,

    // writeback from the rest of the core
    input  logic    ext_wb_valid,
    input  rob_id_t ext_wb_rob_id,
    input  phy_t    ext_wb_rd_phy,
    input  arch_t   ext_wb_rd_arch,
    input  xlen_t   ext_wb_value,

    // md result lane
    output logic    res_valid,
    output rob_id_t res_rob_id,
    output phy_t    res_rd_phy,
    output arch_t   res_rd_arch,
    output xlen_t   res_value
);

    ds_rs_if ds_rs ();
    cdb_if   cdb [CDB_WIDTH] ();

    phy_t      rs1_phy;
    phy_t      rs2_phy;
    xlen_t     rs1_value;
    xlen_t     rs2_value;
    logic      issue_valid;
    logic      fu_ready;
    md_issue_t issue;

    // ------------------------------------------------------------------
    // ports to bundles
    // ------------------------------------------------------------------

    assign ds_rs.valid = disp_valid;
    assign ds_rs.uop   = '{
        rob_id:    disp_rob_id,
        rd_phy:    disp_rd_phy,
        rd_arch:   disp_rd_arch,
        op:        disp_op,
        rs1_phy:   disp_rs1_phy,
        rs1_valid: disp_rs1_valid,
        rs2_phy:   disp_rs2_phy,
        rs2_valid: disp_rs2_valid
    };
    assign disp_ready  = ds_rs.ready;

    // lane 0, external writeback
    assign cdb[0].valid   = ext_wb_valid;
    assign cdb[0].rob_id  = ext_wb_rob_id;
    assign cdb[0].rd_phy  = ext_wb_rd_phy;
    assign cdb[0].rd_arch = ext_wb_rd_arch;
    assign cdb[0].value   = ext_wb_value;

    // lane 1 out as the result
    assign res_valid   = cdb[1].valid;
    assign res_rob_id  = cdb[1].rob_id;
    assign res_rd_phy  = cdb[1].rd_phy;
    assign res_rd_arch = cdb[1].rd_arch;
    assign res_value   = cdb[1].value;

    // ------------------------------------------------------------------
    // blocks
    // ------------------------------------------------------------------

    prf prf_inst (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    intm_rs intm_rs_inst (
        .clk         (clk),
        .rst         (rst),
        .from_ds     (ds_rs),
        .cdb         (cdb),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .issue       (issue),
        .fu_ready    (fu_ready)
    );

    fu_md fu_md_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .fu_ready    (fu_ready),
        .issue       (issue),
        .cdb_out     (cdb[1])
    );

endmodule

`default_nettype wire

//--- hw/fu_md.sv
`timescale 1ns/1ps
`default_nettype none

module fu_md
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    output logic      fu_ready,
    input  md_issue_t issue,
    cdb_if.fu         cdb_out
);

    typedef enum logic [1:0] {IDLE, MUL, DIV, DONE} state_t;

    state_t    state;
    logic      accept;

    // op in flight and its result
    md_issue_t hold;
    xlen_t     result;

    // operand decode
    logic      is_div;
    logic      a_neg;
    logic      b_neg;
    xlen_t     a_mag;
    xlen_t     b_mag;

    // multiply path
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [2*XLEN-1:0] mul_prod;
    logic                     mul_step;
    xlen_t                    mul_res;

    // divide path, restoring on magnitudes
    xlen_t       div_quo;
    xlen_t       div_rem;
    xlen_t       div_dsr;
    logic [5:0]  div_cnt;
    logic        div_neg_q;
    logic        div_neg_r;
    logic [XLEN:0] div_shift;
    logic        div_ge;
    xlen_t       quo_fix;
    xlen_t       rem_fix;
    xlen_t       div_res;

    // one op at a time
    assign fu_ready = (state == IDLE);
    assign accept   = issue_valid && fu_ready;

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------

    always_comb begin
        is_div = issue.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        a_neg  = issue.rs1_value[XLEN-1]
                 && (issue.op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM});
        b_neg  = issue.rs2_value[XLEN-1]
                 && (issue.op inside {OP_MULH, OP_DIV, OP_REM});
        a_mag  = a_neg ? -issue.rs1_value : issue.rs1_value;
        b_mag  = b_neg ? -issue.rs2_value : issue.rs2_value;
    end

    // ------------------------------------------------------------------
    // result select
    // ------------------------------------------------------------------

    assign mul_res = (hold.op == OP_MUL) ? mul_prod[XLEN-1:0] : mul_prod[2*XLEN-1:XLEN];

    // next restoring step
    assign div_shift = {div_rem, div_quo[XLEN-1]};
    assign div_ge    = div_shift >= {1'b0, div_dsr};

    // sign fix
    // 0x80000000 / -1 already lands on the dividend with remainder 0
    always_comb begin
        quo_fix = div_neg_q ? -div_quo : div_quo;
        rem_fix = div_neg_r ? -div_rem : div_rem;
        if (div_dsr == '0) begin
            quo_fix = '1;
            rem_fix = hold.rs1_value;
        end
        div_res = (hold.op inside {OP_REM, OP_REMU}) ? rem_fix : quo_fix;
    end

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            mul_step <= 1'b0;
            div_cnt  <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= is_div ? DIV : MUL;
                        mul_step <= 1'b0;
                        div_cnt  <= '0;
                    end
                end
                // product, then result
                MUL: begin
                    mul_step <= 1'b1;
                    if (mul_step) begin
                        state <= DONE;
                    end
                end
                // 32 steps, then sign fix
                DIV: begin
                    if (div_cnt == 6'(DIV_STEPS)) begin
                        state <= DONE;
                    end else begin
                        div_cnt <= div_cnt + 6'd1;
                    end
                end
                // lane valid for this one cycle
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            hold      <= issue;
            mul_a     <= {a_neg, issue.rs1_value};
            mul_b     <= {b_neg, issue.rs2_value};
            div_quo   <= a_mag;
            div_rem   <= '0;
            div_dsr   <= b_mag;
            div_neg_q <= a_neg ^ b_neg;
            div_neg_r <= a_neg;
        end
        if (state == MUL) begin
            mul_prod <= mul_a * mul_b;
            if (mul_step) begin
                result <= mul_res;
            end
        end
        if (state == DIV) begin
            if (div_cnt == 6'(DIV_STEPS)) begin
                result <= div_res;
            end else begin
                div_rem <= div_ge ? (div_shift[XLEN-1:0] - div_dsr) : div_shift[XLEN-1:0];
                div_quo <= {div_quo[XLEN-2:0], div_ge};
            end
        end
    end

    // broadcast
    assign cdb_out.valid   = (state == DONE);
    assign cdb_out.rob_id  = hold.rob_id;
    assign cdb_out.rd_phy  = hold.rd_phy;
    assign cdb_out.rd_arch = hold.rd_arch;
    assign cdb_out.value   = result;

endmodule

`default_nettype wire

//--- hw/intm_rs.sv
`timescale 1ns/1ps
`default_nettype none

module intm_rs
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    ds_rs_if.rs       from_ds,
    cdb_if.rs         cdb[CDB_WIDTH],

    // operand read, combinational
    output phy_t      rs1_phy,
    output phy_t      rs2_phy,
    input  xlen_t     rs1_value,
    input  xlen_t     rs2_value,

    // issue to md unit
    output logic      issue_valid,
    output md_issue_t issue,
    input  logic      fu_ready
);

    // ------------------------------------------------------------------
    // cdb snoop
    // ------------------------------------------------------------------

    logic [CDB_WIDTH-1:0] lane_valid;
    phy_t                 lane_phy [CDB_WIDTH];

    generate
        for (genvar i = 0; i < CDB_WIDTH; i++) begin : g_lane
            assign lane_valid[i] = cdb[i].valid;
            assign lane_phy[i]   = cdb[i].rd_phy;
        end
    endgenerate

    // any lane broadcasting this tag right now
    function automatic logic lane_hit(phy_t phy);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (lane_valid[k] && (lane_phy[k] == phy)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ------------------------------------------------------------------
    // station array
    // ------------------------------------------------------------------

    uop_t                    entry [INTMRS_DEPTH];
    logic [INTMRS_DEPTH-1:0] busy;

    logic    push_en;
    rs_idx_t push_idx;
    uop_t    push_uop;

    logic    sel_en;
    rs_idx_t sel_idx;
    logic    fire;

    // room left
    assign from_ds.ready = ~&busy;
    assign push_en       = from_ds.valid && from_ds.ready;

    // lowest free slot, scanned top down
    always_comb begin
        push_idx = '0;
        for (int i = INTMRS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                push_idx = rs_idx_t'(i);
            end
        end
    end

    // a broadcast in the push cycle would otherwise be missed
    always_comb begin
        push_uop           = from_ds.uop;
        push_uop.rs1_valid = from_ds.uop.rs1_valid || lane_hit(from_ds.uop.rs1_phy);
        push_uop.rs2_valid = from_ds.uop.rs2_valid || lane_hit(from_ds.uop.rs2_phy);
    end

    // select, highest ready entry wins
    // same-cycle lane hits count as ready
    always_comb begin
        sel_en  = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < INTMRS_DEPTH; i++) begin
            if (busy[i]
                && (entry[i].rs1_valid || lane_hit(entry[i].rs1_phy))
                && (entry[i].rs2_valid || lane_hit(entry[i].rs2_phy))) begin
                sel_en  = 1'b1;
                sel_idx = rs_idx_t'(i);
            end
        end
    end

    assign fire = sel_en && fu_ready;

    // occupancy
    // push only lands in a free slot, issue only frees a busy one
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (push_en) begin
                busy[push_idx] <= 1'b1;
            end
            if (fire) begin
                busy[sel_idx] <= 1'b0;
            end
        end
    end

    // entry payload and wakeup bits
    always_ff @(posedge clk) begin
        for (int i = 0; i < INTMRS_DEPTH; i++) begin
            if (busy[i]) begin
                if (lane_hit(entry[i].rs1_phy)) begin
                    entry[i].rs1_valid <= 1'b1;
                end
                if (lane_hit(entry[i].rs2_phy)) begin
                    entry[i].rs2_valid <= 1'b1;
                end
            end
        end
        if (push_en) begin
            entry[push_idx] <= push_uop;
        end
    end

    // ------------------------------------------------------------------
    // operand read and issue
    // ------------------------------------------------------------------

    assign rs1_phy = entry[sel_idx].rs1_phy;
    assign rs2_phy = entry[sel_idx].rs2_phy;

    assign issue_valid = sel_en;

    // values come back through the prf bypass
    always_comb begin
        issue.rob_id    = entry[sel_idx].rob_id;
        issue.rd_phy    = entry[sel_idx].rd_phy;
        issue.rd_arch   = entry[sel_idx].rd_arch;
        issue.op        = entry[sel_idx].op;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

endmodule

`default_nettype wire

//--- hw/prf.sv
`timescale 1ns/1ps
`default_nettype none

module prf
    import md_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    cdb_if.prf    cdb[CDB_WIDTH],
    input  phy_t  rs1_phy,
    input  phy_t  rs2_phy,
    output xlen_t rs1_value,
    output xlen_t rs2_value
);

    xlen_t regs [PRF_DEPTH];

    // flat copy of the write lanes
    logic [CDB_WIDTH-1:0] wr_valid;
    phy_t                 wr_phy   [CDB_WIDTH];
    xlen_t                wr_value [CDB_WIDTH];

    generate
        for (genvar i = 0; i < CDB_WIDTH; i++) begin : g_lane
            assign wr_valid[i] = cdb[i].valid;
            assign wr_phy[i]   = cdb[i].rd_phy;
            assign wr_value[i] = cdb[i].value;
        end
    endgenerate

    // every valid lane writes, p0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (wr_valid[k] && (wr_phy[k] != '0)) begin
                    regs[wr_phy[k]] <= wr_value[k];
                end
            end
        end
    end

    // read with bypass of a same-cycle broadcast
    function automatic xlen_t read_port(phy_t phy);
        xlen_t val;
        val = regs[phy];
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (wr_valid[k] && (wr_phy[k] == phy) && (phy != '0)) begin
                val = wr_value[k];
            end
        end
        return val;
    endfunction

    always_comb begin
        rs1_value = read_port(rs1_phy);
        rs2_value = read_port(rs2_phy);
    end

endmodule

`default_nettype wire

//--- hw/cdb_if.sv
`timescale 1ns/1ps
`default_nettype none

// one lane of the common data bus
// single cycle broadcast, no back-pressure
interface cdb_if
    import md_pkg::*;
();

    logic    valid;
    rob_id_t rob_id;
    phy_t    rd_phy;
    arch_t   rd_arch;
    xlen_t   value;

    // producer
    modport fu (
        output valid,
        output rob_id,
        output rd_phy,
        output rd_arch,
        output value
    );

    // wakeup only needs the tag
    modport rs (
        input valid,
        input rd_phy
    );

    // register write
    modport prf (
        input valid,
        input rd_phy,
        input value
    );

endinterface

`default_nettype wire

//--- hw/ds_rs_if.sv
`timescale 1ns/1ps
`default_nettype none

// dispatch to reservation station, valid/ready
interface ds_rs_if
    import md_pkg::*;
();

    logic valid;
    logic ready;
    uop_t uop;

    // dispatch side holds valid and uop until ready
    modport dispatch (
        output valid,
        output uop,
        input  ready
    );

    // station side, ready while any entry is free
    modport rs (
        input  valid,
        input  uop,
        output ready
    );

endinterface

`default_nettype wire

//--- hw/md_pkg.sv
`default_nettype none

package md_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------

    localparam int XLEN         = 32;
    localparam int PRF_DEPTH    = 64;
    localparam int PHY_W        = $clog2(PRF_DEPTH);
    localparam int ROB_W        = 5;
    localparam int ARCH_W       = 5;

    // lane 0 is external writeback, lane 1 is the md unit
    localparam int CDB_WIDTH    = 2;

    localparam int INTMRS_DEPTH = 4;
    localparam int INTMRS_IDX   = 2;

    // one quotient bit per step
    localparam int DIV_STEPS    = 32;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [PHY_W-1:0]      phy_t;
    typedef logic [ROB_W-1:0]      rob_id_t;
    typedef logic [ARCH_W-1:0]     arch_t;
    typedef logic [INTMRS_IDX-1:0] rs_idx_t;

    // encoded as funct3 of the M extension, bit 2 marks divide
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } md_op_t;

    // renamed op, dispatch payload and station entry
    typedef struct packed {
        rob_id_t rob_id;
        phy_t    rd_phy;
        arch_t   rd_arch;
        md_op_t  op;
        phy_t    rs1_phy;
        logic    rs1_valid;
        phy_t    rs2_phy;
        logic    rs2_valid;
    } uop_t;

    // op with operand values, station to md unit
    typedef struct packed {
        rob_id_t rob_id;
        phy_t    rd_phy;
        arch_t   rd_arch;
        md_op_t  op;
        xlen_t   rs1_value;
        xlen_t   rs2_value;
    } md_issue_t;

endpackage

`default_nettype wire
